//--- design/bus_interconnect.sv
// Registered one-master address decoder to NUM_SLAVES targets, with the
// OR/AND merged return path registered back to the master
`timescale 1ns/1ps

module bus_interconnect #(
        parameter int NUM_SLAVES = 1,
        parameter sb_map_pkg::sb_range_t [NUM_SLAVES-1:0] SLAVE_MAP = '0
) (
        input logic clock,
        input logic rst_n,
        simple_bus.target master,
        simple_bus.initiator slaves [NUM_SLAVES]
);

        import sb_bus_pkg::*;

        // Return lines gathered from the slave interfaces
        sb_word_t slave_read_data [NUM_SLAVES];
        logic [NUM_SLAVES-1:0] slave_read_valid;
        logic [NUM_SLAVES-1:0] slave_ready;
        sb_word_t merged_read_data;

        for (genvar i = 0; i < NUM_SLAVES; i++) begin : gen_slave
                logic hit;

                // Half-open window check
                assign hit = (master.address >= SLAVE_MAP[i].base) &&
                             (master.address < SLAVE_MAP[i].limit);

                // Non-matching slaves see an all-zero request
                always_ff @(posedge clock) begin
                        if (!rst_n || !hit) begin
                                slaves[i].address <= '0;
                                slaves[i].write_strobe <= 1'b0;
                                slaves[i].read_strobe <= 1'b0;
                                slaves[i].write_data <= '0;
                        end else begin
                                slaves[i].address <= master.address;
                                slaves[i].write_strobe <= master.write_strobe;
                                slaves[i].read_strobe <= master.read_strobe;
                                slaves[i].write_data <= master.write_data;
                        end
                end

                assign slave_read_data[i] = slaves[i].read_data;
                assign slave_read_valid[i] = slaves[i].read_valid;
                assign slave_ready[i] = slaves[i].ready;
        end

        // Idle slaves hold read_data at zero, so a plain OR merges them
        always_comb begin
                merged_read_data = '0;
                for (int i = 0; i < NUM_SLAVES; i++) begin
                        merged_read_data = merged_read_data | slave_read_data[i];
                end
        end

        always_ff @(posedge clock) begin
                if (!rst_n) begin
                        master.read_data <= '0;
                        master.read_valid <= 1'b0;
                        master.ready <= 1'b0;
                end else begin
                        master.read_data <= merged_read_data;
                        master.read_valid <= |slave_read_valid;
                        // Master may issue only when every slave is ready
                        master.ready <= &slave_ready;
                end
        end

endmodule

//--- design/interval_timer.sv
// Interval timer with control, period, count and status registers,
// acting as a simple bus target
`timescale 1ns/1ps

module interval_timer #(
        parameter sb_bus_pkg::sb_addr_t BASE = '0
) (
        input logic clock,
        input logic rst_n,
        simple_bus.target bus
);

        import sb_bus_pkg::*;
        import sb_map_pkg::*;

        logic enable;
        sb_word_t period;
        sb_word_t count;
        logic wrap_flag;
        logic wrap;
        sb_addr_t reg_offset;
        sb_word_t read_word;

        assign reg_offset = bus.address - BASE;

        // Also catches a period lowered below the running count
        assign wrap = enable && (count >= period);

        // Control and period writes; count is read-only
        always_ff @(posedge clock) begin
                if (!rst_n) begin
                        enable <= 1'b0;
                        period <= '0;
                end else if (bus.write_strobe) begin
                        case (reg_offset)
                                TIMER_CTRL: enable <= bus.write_data[0];
                                TIMER_PERIOD: period <= bus.write_data;
                                default: ;
                        endcase
                end
        end

        always_ff @(posedge clock) begin
                if (!rst_n) begin
                        count <= '0;
                end else if (wrap) begin
                        count <= '0;
                end else if (enable) begin
                        count <= count + 1'b1;
                end
        end

        // A wrap in the same cycle as the clearing write still sets the flag
        always_ff @(posedge clock) begin
                if (!rst_n) begin
                        wrap_flag <= 1'b0;
                end else if (wrap) begin
                        wrap_flag <= 1'b1;
                end else if (bus.write_strobe && (reg_offset == TIMER_STATUS)) begin
                        wrap_flag <= 1'b0;
                end
        end

        always_comb begin
                case (reg_offset)
                        TIMER_CTRL: read_word = {{($bits(sb_word_t) - 1){1'b0}}, enable};
                        TIMER_PERIOD: read_word = period;
                        TIMER_COUNT: read_word = count;
                        TIMER_STATUS: read_word = {{($bits(sb_word_t) - 1){1'b0}}, wrap_flag};
                        default: read_word = '0;
                endcase
        end

        // Same response timing as the register banks
        always_ff @(posedge clock) begin
                if (!rst_n) begin
                        bus.read_data <= '0;
                        bus.read_valid <= 1'b0;
                        bus.ready <= 1'b0;
                end else begin
                        bus.read_valid <= bus.read_strobe;
                        bus.read_data <= bus.read_strobe ? read_word : '0;
                        bus.ready <= 1'b1;
                end
        end

endmodule

//--- design/register_bank.sv
// Word-addressed register bank acting as a simple bus target
`timescale 1ns/1ps

module register_bank #(
        parameter int DEPTH = 16,
        parameter sb_bus_pkg::sb_addr_t BASE = '0
) (
        input logic clock,
        input logic rst_n,
        simple_bus.target bus
);

        import sb_bus_pkg::*;

        localparam int INDEX_WIDTH = $clog2(DEPTH);

        sb_word_t storage [DEPTH];
        sb_addr_t word_offset;
        logic [INDEX_WIDTH-1:0] word_index;

        // Interconnect forwards only in-window requests, so the low bits suffice
        assign word_offset = (bus.address - BASE) / SB_WORD_BYTES;
        assign word_index = word_offset[INDEX_WIDTH-1:0];

        // Storage
        always_ff @(posedge clock) begin
                if (!rst_n) begin
                        for (int i = 0; i < DEPTH; i++) begin
                                storage[i] <= '0;
                        end
                end else if (bus.write_strobe) begin
                        storage[word_index] <= bus.write_data;
                end
        end

        // One-cycle read response, data zero outside it
        always_ff @(posedge clock) begin
                if (!rst_n) begin
                        bus.read_data <= '0;
                        bus.read_valid <= 1'b0;
                        bus.ready <= 1'b0;
                end else begin
                        bus.read_valid <= bus.read_strobe;
                        if (bus.read_strobe) begin
                                bus.read_data <= storage[word_index];
                        end else begin
                                bus.read_data <= '0;
                        end
                        // Never busy once out of reset
                        bus.ready <= 1'b1;
                end
        end

endmodule

//--- design/sb_bus_pkg.sv
// Bus word and address types, bus widths and the bytes-per-word constant
// shared by every simple bus block
package sb_bus_pkg;

        // Bus widths
        localparam int SB_ADDR_WIDTH = 32;
        localparam int SB_DATA_WIDTH = 32;

        // Byte address as seen on the bus
        typedef logic [SB_ADDR_WIDTH-1:0] sb_addr_t;

        // Data word on the write and read paths
        typedef logic [SB_DATA_WIDTH-1:0] sb_word_t;

        // Word index of a byte offset is offset / SB_WORD_BYTES
        localparam int SB_WORD_BYTES = SB_DATA_WIDTH / 8;

endpackage

//--- design/sb_map_pkg.sv
// Address map definitions: slave window type, slave count and
// interval timer register offsets
package sb_map_pkg;

        import sb_bus_pkg::*;

        // One slave window, base included and limit excluded
        typedef struct packed {
                sb_addr_t base;
                sb_addr_t limit;
        } sb_range_t;

        // Slave ports behind the interconnect
        localparam int SB_NUM_SLAVES = 3;

        // Interval timer registers, byte offsets from the timer base
        localparam sb_addr_t TIMER_CTRL = 32'h0000_0000;
        localparam sb_addr_t TIMER_PERIOD = 32'h0000_0004;
        localparam sb_addr_t TIMER_COUNT = 32'h0000_0008;
        localparam sb_addr_t TIMER_STATUS = 32'h0000_000c;

endpackage

//--- design/sb_subsystem.sv
// Simple bus subsystem top level: plain master ports, address decoder,
// two register banks and an interval timer
`timescale 1ns/1ps

module sb_subsystem (
        input logic clock,
        input logic rst_n,
        input sb_bus_pkg::sb_addr_t sb_address,
        input logic sb_write_strobe,
        input logic sb_read_strobe,
        input sb_bus_pkg::sb_word_t sb_write_data,
        output sb_bus_pkg::sb_word_t sb_read_data,
        output logic sb_read_valid,
        output logic sb_ready
);

        import sb_map_pkg::*;

        // Address map
        localparam sb_range_t BANK0_RANGE = '{base: 32'h0000_0000, limit: 32'h0000_0040};
        localparam sb_range_t BANK1_RANGE = '{base: 32'h0000_1000, limit: 32'h0000_1020};
        localparam sb_range_t TIMER_RANGE = '{base: 32'h0000_2000, limit: 32'h0000_2010};
        localparam int BANK0_DEPTH = 16;
        localparam int BANK1_DEPTH = 8;

        // Slave port 0 is bank 0, 1 is bank 1, 2 is the timer
        localparam sb_range_t [SB_NUM_SLAVES-1:0] SLAVE_MAP =
                {TIMER_RANGE, BANK1_RANGE, BANK0_RANGE};

        simple_bus master_bus ();
        simple_bus slave_bus [SB_NUM_SLAVES] ();

        assign master_bus.address = sb_address;
        assign master_bus.write_strobe = sb_write_strobe;
        assign master_bus.read_strobe = sb_read_strobe;
        assign master_bus.write_data = sb_write_data;
        assign sb_read_data = master_bus.read_data;
        assign sb_read_valid = master_bus.read_valid;
        assign sb_ready = master_bus.ready;

        bus_interconnect #(
                .NUM_SLAVES(SB_NUM_SLAVES),
                .SLAVE_MAP(SLAVE_MAP)
        ) interconnect_inst (
                .clock(clock),
                .rst_n(rst_n),
                .master(master_bus),
                .slaves(slave_bus)
        );

        register_bank #(
                .DEPTH(BANK0_DEPTH),
                .BASE(BANK0_RANGE.base)
        ) bank0_inst (
                .clock(clock),
                .rst_n(rst_n),
                .bus(slave_bus[0])
        );

        register_bank #(
                .DEPTH(BANK1_DEPTH),
                .BASE(BANK1_RANGE.base)
        ) bank1_inst (
                .clock(clock),
                .rst_n(rst_n),
                .bus(slave_bus[1])
        );

        interval_timer #(
                .BASE(TIMER_RANGE.base)
        ) timer_inst (
                .clock(clock),
                .rst_n(rst_n),
                .bus(slave_bus[2])
        );

endmodule

//--- design/simple_bus.sv
// Simple strobe bus interface with initiator and target modports
`timescale 1ns/1ps

interface simple_bus;

        import sb_bus_pkg::*;

        // Request, driven by the initiator
        sb_addr_t address;
        logic write_strobe;
        logic read_strobe;
        sb_word_t write_data;

        // Response, driven by the target
        sb_word_t read_data;
        logic read_valid;
        logic ready;

        modport initiator (
                output address,
                output write_strobe,
                output read_strobe,
                output write_data,
                input read_data,
                input read_valid,
                input ready
        );

        modport target (
                input address,
                input write_strobe,
                input read_strobe,
                input write_data,
                output read_data,
                output read_valid,
                output ready
        );

endinterface

//--- run_sim.sh
#!/usr/bin/env bash
# Build the simple bus subsystem testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
        -f sb_subsystem.f --top-module sb_subsystem_tb -o sb_subsystem_sim

./obj_dir/sb_subsystem_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
        echo "Simulation passed"
else
        echo "Simulation failed, see sim.log"
        exit 1
fi

//--- sb_subsystem.f
+incdir+test
design/sb_bus_pkg.sv
design/sb_map_pkg.sv
design/simple_bus.sv
design/bus_interconnect.sv
design/register_bank.sv
design/interval_timer.sv
design/sb_subsystem.sv
test/sb_subsystem_tb.sv

//--- test/sb_bus_tasks.svh
// Bus write and read tasks driven on the falling clock edge, and the
// reference model of both register banks

// Slots 0 to 15 mirror bank 0, slots 16 to 23 mirror bank 1
sb_word_t bank_model [BANK0_WORDS + BANK1_WORDS];

function automatic int model_slot(input sb_addr_t addr);
        if (addr >= BANK1_BASE) begin
                return BANK0_WORDS + int'((addr - BANK1_BASE) / SB_WORD_BYTES);
        end
        return int'((addr - BANK0_BASE) / SB_WORD_BYTES);
endfunction

// Banks come out of reset all zero
task automatic model_clear();
        for (int i = 0; i < BANK0_WORDS + BANK1_WORDS; i++) begin
                bank_model[i] = '0;
        end
endtask

task automatic wait_ready();
        while (!sb_ready) begin
                @(negedge clock);
        end
endtask

// One-cycle write pulse
task automatic bus_write(input sb_addr_t addr, input sb_word_t data);
        wait_ready();
        sb_address = addr;
        sb_write_data = data;
        sb_write_strobe = 1'b1;
        @(negedge clock);
        sb_write_strobe = 1'b0;
endtask

// Write to a bank word and keep the model in step
task automatic bank_write(input sb_addr_t addr, input sb_word_t data);
        bus_write(addr, data);
        bank_model[model_slot(addr)] = data;
endtask

// Latency is the cycle read_valid showed up in, 0 if it never did
task automatic bus_read(input sb_addr_t addr, output sb_word_t data, output int latency);
        int cycle;
        wait_ready();
        sb_address = addr;
        sb_read_strobe = 1'b1;
        data = '0;
        latency = 0;
        cycle = 0;
        while (latency == 0 && cycle < READ_WAIT_LIMIT) begin
                @(negedge clock);
                sb_read_strobe = 1'b0;
                cycle++;
                if (sb_read_valid) begin
                        latency = cycle;
                        data = sb_read_data;
                end
        end
endtask

//--- test/sb_subsystem_tb.sv
// Testbench for the simple bus subsystem: reset, bank read-back, decode
// boundaries and interval timer checks with a cycle limit
`timescale 1ns/1ps

module sb_subsystem_tb;

        import sb_bus_pkg::*;
        import sb_map_pkg::*;

        localparam int RESET_CYCLES = 10;
        // The whole sequence needs a few hundred cycles
        localparam int TIMEOUT_CYCLES = 4000;
        localparam int READ_LATENCY = 3;
        localparam int READ_WAIT_LIMIT = 5;
        localparam int RANDOM_WRITES = 12;
        localparam int BANK0_WORDS = 16;
        localparam int BANK1_WORDS = 8;
        localparam sb_addr_t BANK0_BASE = 32'h0000_0000;
        localparam sb_addr_t BANK1_BASE = 32'h0000_1000;
        localparam sb_addr_t TIMER_BASE = 32'h0000_2000;
        // Window limits in slave port order
        localparam sb_addr_t [SB_NUM_SLAVES-1:0] WINDOW_LIMIT =
                {32'h0000_2010, 32'h0000_1020, 32'h0000_0040};

        logic clock = 1'b0;
        logic rst_n;
        sb_addr_t sb_address;
        logic sb_write_strobe;
        logic sb_read_strobe;
        sb_word_t sb_write_data;
        sb_word_t sb_read_data;
        logic sb_read_valid;
        logic sb_ready;

        string current_test;
        int test_errors;
        int tests_run;
        int tests_failed;
        int total_errors;
        int cycle_count;

        `include "sb_bus_tasks.svh"

        sb_subsystem sb_subsystem_inst (
                .clock(clock),
                .rst_n(rst_n),
                .sb_address(sb_address),
                .sb_write_strobe(sb_write_strobe),
                .sb_read_strobe(sb_read_strobe),
                .sb_write_data(sb_write_data),
                .sb_read_data(sb_read_data),
                .sb_read_valid(sb_read_valid),
                .sb_ready(sb_ready)
        );

        // 20 ns clock
        initial begin
                forever begin
                        #10 clock = ~clock;
                end
        end

        initial begin
                cycle_count = 0;
                while (cycle_count < TIMEOUT_CYCLES) begin
                        @(posedge clock);
                        cycle_count++;
                end
                $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("Test failed");
                $finish;
        end

        task automatic begin_test(input string name);
                current_test = name;
                test_errors = 0;
        endtask

        task automatic end_test();
                tests_run++;
                total_errors += test_errors;
                if (test_errors != 0) begin
                        tests_failed++;
                end
                $display("%s: finished with %0d errors", current_test, test_errors);
        endtask

        task automatic check_equal(input sb_word_t expected, input sb_word_t actual);
                assert (actual === expected) else begin
                        $display("Error: %s expected %h actual %h", current_test, expected, actual);
                        test_errors++;
                end
        endtask

        task automatic check_true(input logic condition, input string what);
                assert (condition) else begin
                        $display("%s: %s", current_test, what);
                        test_errors++;
                end
        endtask

        task automatic read_register(input sb_addr_t addr, output sb_word_t data);
                int latency;
                bus_read(addr, data, latency);
                check_true(latency == READ_LATENCY,
                           $sformatf("read at %h got read_valid at cycle %0d, not 3", addr, latency));
        endtask

        task automatic expect_read(input sb_addr_t addr, input sb_word_t expected);
                sb_word_t data;
                read_register(addr, data);
                check_equal(expected, data);
        endtask

        task automatic expect_no_response(input sb_addr_t addr);
                sb_word_t data;
                int latency;
                bus_read(addr, data, latency);
                check_true(latency == 0, $sformatf("read at %h unexpectedly answered", addr));
        endtask

        task automatic verify_reset_state();
                int wait_cycles;
                begin_test("reset_state");
                repeat (RESET_CYCLES) @(negedge clock);
                check_true(!sb_read_valid && !sb_ready, "read_valid or ready high during reset");
                check_equal(32'h0, sb_read_data);
                rst_n = 1'b1;
                wait_cycles = 0;
                while (!sb_ready && wait_cycles < READ_WAIT_LIMIT) begin
                        @(negedge clock);
                        wait_cycles++;
                end
                check_true(sb_ready && wait_cycles <= 2, "ready did not rise within two cycles");
                check_true(!sb_read_valid, "read_valid high after reset release");
                check_equal(32'h0, sb_read_data);
                end_test();
        endtask

        task automatic bank_readback();
                sb_addr_t addr;
                begin_test("bank_readback");
                for (int n = 0; n < RANDOM_WRITES; n++) begin
                        addr = BANK0_BASE + $urandom_range(BANK0_WORDS - 1, 0) * SB_WORD_BYTES;
                        bank_write(addr, $urandom());
                        addr = BANK1_BASE + $urandom_range(BANK1_WORDS - 1, 0) * SB_WORD_BYTES;
                        bank_write(addr, $urandom());
                end
                // Same word index in both banks must not alias
                bank_write(BANK0_BASE, 32'h0a0a_0a0a);
                bank_write(BANK1_BASE, 32'hb1b1_b1b1);
                for (int i = 0; i < BANK0_WORDS + BANK1_WORDS; i++) begin
                        addr = (i < BANK0_WORDS) ? BANK0_BASE + i * SB_WORD_BYTES :
                                BANK1_BASE + (i - BANK0_WORDS) * SB_WORD_BYTES;
                        expect_read(addr, bank_model[model_slot(addr)]);
                end
                end_test();
        endtask

        task automatic decode_boundaries();
                begin_test("decode_boundaries");
                bank_write(WINDOW_LIMIT[0] - SB_WORD_BYTES, 32'h1111_0000);
                bank_write(WINDOW_LIMIT[1] - SB_WORD_BYTES, 32'h2222_0000);
                bus_write(WINDOW_LIMIT[0], 32'hdead_0000);
                bus_write(WINDOW_LIMIT[1], 32'hdead_0001);
                expect_read(WINDOW_LIMIT[0] - SB_WORD_BYTES, 32'h1111_0000);
                expect_read(WINDOW_LIMIT[1] - SB_WORD_BYTES, 32'h2222_0000);
                // A limit write that leaked in would wrap onto word 0
                expect_read(BANK0_BASE, bank_model[model_slot(BANK0_BASE)]);
                expect_read(BANK1_BASE, bank_model[model_slot(BANK1_BASE)]);
                // Limits, holes above each window, top of the address space
                for (int s = 0; s < SB_NUM_SLAVES; s++) begin
                        expect_no_response(WINDOW_LIMIT[s]);
                        expect_no_response(WINDOW_LIMIT[s] + 32'h400);
                end
                expect_no_response(32'hffff_fffc);
                end_test();
        endtask

        task automatic timer_counting();
                sb_word_t first;
                sb_word_t second;
                begin_test("timer_counting");
                bus_write(TIMER_BASE + TIMER_PERIOD, 32'd1000);
                bus_write(TIMER_BASE + TIMER_CTRL, 32'h1);
                read_register(TIMER_BASE + TIMER_COUNT, first);
                read_register(TIMER_BASE + TIMER_COUNT, second);
                check_true(second > first, $sformatf("count went %0d then %0d", first, second));
                // Short period, run well past it so the count must have wrapped
                bus_write(TIMER_BASE + TIMER_PERIOD, 32'd3);
                repeat (8) @(negedge clock);
                read_register(TIMER_BASE + TIMER_COUNT, first);
                read_register(TIMER_BASE + TIMER_COUNT, second);
                check_true(first <= 32'd3 && second <= 32'd3,
                           $sformatf("count read %0d and %0d with period 3", first, second));
                bus_write(TIMER_BASE + TIMER_CTRL, 32'h0);
                read_register(TIMER_BASE + TIMER_COUNT, first);
                read_register(TIMER_BASE + TIMER_COUNT, second);
                check_equal(first, second);
                end_test();
        endtask

        task automatic timer_wrap_flag();
                sb_word_t data;
                begin_test("timer_wrap_flag");
                bus_write(TIMER_BASE + TIMER_PERIOD, 32'd4);
                bus_write(TIMER_BASE + TIMER_STATUS, 32'h0);
                bus_write(TIMER_BASE + TIMER_CTRL, 32'h1);
                // More than period + 1 cycles
                repeat (8) @(negedge clock);
                read_register(TIMER_BASE + TIMER_STATUS, data);
                check_equal(32'h1, data & 32'h1);
                bus_write(TIMER_BASE + TIMER_CTRL, 32'h0);
                bus_write(TIMER_BASE + TIMER_STATUS, 32'h0);
                read_register(TIMER_BASE + TIMER_STATUS, data);
                check_equal(32'h0, data & 32'h1);
                end_test();
        endtask

        initial begin
                void'($urandom(32'h7410be98));
                rst_n = 1'b0;
                sb_address = '0;
                sb_write_strobe = 1'b0;
                sb_read_strobe = 1'b0;
                sb_write_data = '0;
                tests_run = 0;
                tests_failed = 0;
                total_errors = 0;
                model_clear();
                verify_reset_state();
                bank_readback();
                decode_boundaries();
                timer_counting();
                timer_wrap_flag();
                $display("%0d tests run, %0d with errors, %0d failed checks",
                         tests_run, tests_failed, total_errors);
                if (total_errors == 0) begin
                        $display("Test passed");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule
